//--- common/plic_pkg.sv
package plic_pkg;

    // bus widths
    localparam int addr_width = 12;
    localparam int data_width = 32;
    localparam int pri_width  = 8;

    // byte address map
    localparam logic [addr_width-1:0] en_addr   = 12'h000;
    localparam logic [addr_width-1:0] pri_base  = 12'h010; // one byte per source
    localparam logic [addr_width-1:0] id_addr   = 12'h040;
    localparam logic [addr_width-1:0] mvec_addr = 12'h044;
    localparam logic [addr_width-1:0] marg_addr = 12'h048;
    localparam logic [addr_width-1:0] vec_base  = 12'h100; // one word per source
    localparam logic [addr_width-1:0] obj_base  = 12'h200; // one word per source

    // decoded region of a register address
    typedef enum logic [2:0] {
        region_none,
        region_en,
        region_pri,
        region_id,
        region_mvec,
        region_marg,
        region_vec,
        region_obj
    } reg_region_e;

endpackage

//--- rtl/irq_gateway.sv
`timescale 1ns/1ps

module irq_gateway #(
    parameter int num_sources = 16
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [num_sources-1:0] irq_sources,
    input  logic [num_sources-1:0] int_en,
    output logic [num_sources-1:0] pending
);

    logic [num_sources-1:0] sync_q1; // may go metastable
    logic [num_sources-1:0] sync_q2;

    // two-flop synchronizer, one pair per source
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync_q1 <= '0;
            sync_q2 <= '0;
        end else begin
            sync_q1 <= irq_sources;
            sync_q2 <= sync_q1;
        end
    end

    // enable mask is applied after the sync so an enable write acts next edge
    assign pending = sync_q2 & int_en;

endmodule

//--- plic_regs/plic_regs.sv
`timescale 1ns/1ps

module plic_regs #(
    parameter int num_sources = 16
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic [plic_pkg::addr_width-1:0]     waddr,
    input  logic [plic_pkg::data_width-1:0]     wdata,
    input  logic [3:0]                          wstrb,
    input  logic                                wen,
    input  logic [plic_pkg::addr_width-1:0]     raddr,
    output logic [plic_pkg::data_width-1:0]     rdata,
    input  logic [$clog2(num_sources)-1:0]      irq_id,
    input  logic [plic_pkg::data_width-1:0]     mvec,
    input  logic [plic_pkg::data_width-1:0]     marg,
    output logic [num_sources-1:0]              int_en,
    output logic [plic_pkg::pri_width-1:0]      int_pri [num_sources],
    output logic [plic_pkg::data_width-1:0]     vectable [num_sources],
    output logic [plic_pkg::data_width-1:0]     objtable [num_sources]
);

    import plic_pkg::*;

    localparam int id_w = $clog2(num_sources);

    reg_region_e           wr_region;
    reg_region_e           rd_region;
    logic [addr_width-1:0] wr_off;    // offset into the decoded region
    logic [addr_width-1:0] rd_off;
    logic [id_w-1:0]       wr_widx;   // table word index
    logic [id_w-1:0]       rd_widx;

    function automatic reg_region_e decode(input logic [addr_width-1:0] addr);
        reg_region_e r;
        r = region_none;
        if (addr == en_addr)
            r = region_en;
        else if (addr >= pri_base && addr < pri_base + num_sources)
            r = region_pri;
        else if (addr == id_addr)
            r = region_id;
        else if (addr == mvec_addr)
            r = region_mvec;
        else if (addr == marg_addr)
            r = region_marg;
        else if (addr[1:0] == 2'b00 && addr >= vec_base && addr < vec_base + 4 * num_sources)
            r = region_vec;
        else if (addr[1:0] == 2'b00 && addr >= obj_base && addr < obj_base + 4 * num_sources)
            r = region_obj;
        return r;
    endfunction

    function automatic logic [addr_width-1:0] region_base(input reg_region_e r);
        case (r)
            region_pri: return pri_base;
            region_vec: return vec_base;
            region_obj: return obj_base;
            default:    return '0;
        endcase
    endfunction

    assign wr_region = decode(waddr);
    assign rd_region = decode(raddr);
    assign wr_off    = waddr - region_base(wr_region);
    assign rd_off    = raddr - region_base(rd_region);
    assign wr_widx   = wr_off[id_w+1:2];
    assign rd_widx   = rd_off[id_w+1:2];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            int_en <= '0;
            for (int i = 0; i < num_sources; i++) begin
                int_pri[i]  <= '0;
                vectable[i] <= '0;
                objtable[i] <= '0;
            end
        end else if (wen) begin
            case (wr_region)
                region_en: begin
                    // lane k covers enable bits 8k..8k+7
                    for (int i = 0; i < num_sources; i++)
                        if (wstrb[i/8])
                            int_en[i] <= wdata[i];
                end
                region_pri: begin
                    for (int k = 0; k < 4; k++)
                        if (wstrb[k] && (int'(wr_off) + k < num_sources))
                            int_pri[int'(wr_off) + k] <= wdata[8*k +: 8];
                end
                region_vec: vectable[wr_widx] <= wdata; // full word, wstrb ignored
                region_obj: objtable[wr_widx] <= wdata;
                default: ; // id, mvec, marg are read only
            endcase
        end
    end

    always_comb begin
        rdata = '0;
        case (rd_region)
            region_en:   rdata = data_width'(int_en);
            region_pri: begin
                for (int k = 0; k < 4; k++)
                    if (int'(rd_off) + k < num_sources)
                        rdata[8*k +: 8] = int_pri[int'(rd_off) + k];
            end
            region_id:   rdata = data_width'(irq_id);
            region_mvec: rdata = mvec;
            region_marg: rdata = marg;
            region_vec:  rdata = vectable[rd_widx];
            region_obj:  rdata = objtable[rd_widx];
            default:     rdata = '0;
        endcase
    end

    // software must select at least one byte lane
    a_wstrb_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
        wen |-> wstrb != 4'b0000)
        else $error("write with empty wstrb at %h", waddr);

endmodule

//--- rtl/priority_arbiter.sv
`timescale 1ns/1ps

module priority_arbiter #(
    parameter int num_sources = 16
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [num_sources-1:0]            pending,
    input  logic [plic_pkg::pri_width-1:0]    int_pri [num_sources],
    output logic [$clog2(num_sources)-1:0]    irq_id,
    output logic                              irq_valid
);

    import plic_pkg::*;

    localparam int id_w   = $clog2(num_sources);
    localparam int leaves = 1 << id_w; // padded to a power of two

    // heap layout, node 1 is the root, leaves at leaves..2*leaves-1
    logic                 node_valid [1:2*leaves-1];
    logic [pri_width-1:0] node_pri   [1:2*leaves-1];
    logic [id_w-1:0]      node_idx   [1:2*leaves-1];

    for (genvar g = 0; g < leaves; g++) begin : g_leaf
        if (g < num_sources) begin : g_src
            assign node_valid[leaves+g] = pending[g];
            assign node_pri[leaves+g]   = int_pri[g];
        end else begin : g_pad
            assign node_valid[leaves+g] = 1'b0;
            assign node_pri[leaves+g]   = '0;
        end
        assign node_idx[leaves+g] = id_w'(g);
    end

    for (genvar n = 1; n < leaves; n++) begin : g_node
        logic take_right;

        // left subtree holds the lower indices, so ties stay left
        assign take_right = node_valid[2*n+1] &&
                            (!node_valid[2*n] || node_pri[2*n+1] > node_pri[2*n]);
        assign node_valid[n] = node_valid[2*n] | node_valid[2*n+1];
        assign node_pri[n]   = take_right ? node_pri[2*n+1] : node_pri[2*n];
        assign node_idx[n]   = take_right ? node_idx[2*n+1] : node_idx[2*n];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            irq_valid <= 1'b0;
            irq_id    <= '0;
        end else begin
            irq_valid <= node_valid[1];
            irq_id    <= node_valid[1] ? node_idx[1] : '0; // id 0 when idle
        end
    end

    // the registered winner was pending at the previous edge
    a_winner_pending: assert property (@(posedge clk) disable iff (!rst_n)
        irq_valid |-> |($past(pending) & (num_sources'(1) << irq_id)))
        else $error("irq_id %0d was not pending", irq_id);

endmodule

//--- rtl/vector_stage.sv
`timescale 1ns/1ps

module vector_stage #(
    parameter int num_sources = 16
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [$clog2(num_sources)-1:0]    irq_id,
    input  logic                              irq_valid,
    input  logic [plic_pkg::data_width-1:0]   vectable [num_sources],
    input  logic [plic_pkg::data_width-1:0]   objtable [num_sources],
    output logic [plic_pkg::data_width-1:0]   mvec,
    output logic [plic_pkg::data_width-1:0]   marg
);

    // handler and argument are captured together so software sees a matched pair
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mvec <= '0;
            marg <= '0;
        end else if (irq_valid) begin
            mvec <= vectable[irq_id];
            marg <= objtable[irq_id];
        end
        // hold last pair while idle
    end

    // padded tree leaves must never reach the tables
    a_id_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        irq_valid |-> int'(irq_id) < num_sources)
        else $error("irq_id %0d out of range", irq_id);

endmodule

//--- rtl/plic_top.sv
`timescale 1ns/1ps

module plic_top #(
    parameter int num_sources = 16
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [plic_pkg::addr_width-1:0]   waddr,
    input  logic [plic_pkg::data_width-1:0]   wdata,
    input  logic [3:0]                        wstrb,
    input  logic                              wen,
    input  logic [plic_pkg::addr_width-1:0]   raddr,
    output logic [plic_pkg::data_width-1:0]   rdata,
    input  logic [num_sources-1:0]            irq_sources, // async levels
    output logic                              irq_valid,
    output logic [$clog2(num_sources)-1:0]    irq_id,
    output logic [plic_pkg::data_width-1:0]   mvec,
    output logic [plic_pkg::data_width-1:0]   marg
);

    import plic_pkg::*;

    logic [num_sources-1:0] int_en;
    logic [num_sources-1:0] pending;
    logic [pri_width-1:0]   int_pri  [num_sources];
    logic [data_width-1:0]  vectable [num_sources];
    logic [data_width-1:0]  objtable [num_sources];

    irq_gateway #(.num_sources(num_sources)) u_gateway (
        .clk         (clk),
        .rst_n       (rst_n),
        .irq_sources (irq_sources),
        .int_en      (int_en),
        .pending     (pending)
    );

    priority_arbiter #(.num_sources(num_sources)) u_arbiter (
        .clk       (clk),
        .rst_n     (rst_n),
        .pending   (pending),
        .int_pri   (int_pri),
        .irq_id    (irq_id),
        .irq_valid (irq_valid)
    );

    vector_stage #(.num_sources(num_sources)) u_vector (
        .clk       (clk),
        .rst_n     (rst_n),
        .irq_id    (irq_id),
        .irq_valid (irq_valid),
        .vectable  (vectable),
        .objtable  (objtable),
        .mvec      (mvec),
        .marg      (marg)
    );

    plic_regs #(.num_sources(num_sources)) u_regs (
        .clk      (clk),
        .rst_n    (rst_n),
        .waddr    (waddr),
        .wdata    (wdata),
        .wstrb    (wstrb),
        .wen      (wen),
        .raddr    (raddr),
        .rdata    (rdata),
        .irq_id   (irq_id),
        .mvec     (mvec),
        .marg     (marg),
        .int_en   (int_en),
        .int_pri  (int_pri),
        .vectable (vectable),
        .objtable (objtable)
    );

endmodule

//--- testbench/tb_plic.sv
`timescale 1ns/1ps

module tb_plic;

    import plic_pkg::*;

    localparam int n_src = 16;
    localparam int n_rw  = 80;  // random register write/read pairs
    localparam int n_irq = 40;  // arbitration trials
    localparam int total_cycles = 8 + 50 + 3 * n_rw + 50 + 70 + 26 * n_irq + 30;

    logic                     clk;
    logic                     rst_n;
    logic [addr_width-1:0]    waddr;
    logic [data_width-1:0]    wdata;
    logic [3:0]               wstrb;
    logic                     wen;
    logic [addr_width-1:0]    raddr;
    logic [data_width-1:0]    rdata;
    logic [n_src-1:0]         irq_sources;
    logic                     irq_valid;
    logic [$clog2(n_src)-1:0] irq_id;
    logic [data_width-1:0]    mvec;
    logic [data_width-1:0]    marg;

    // shadow state of the model
    logic [n_src-1:0]         m_en;
    logic [pri_width-1:0]     m_pri [n_src];
    logic [data_width-1:0]    m_vec [n_src];
    logic [data_width-1:0]    m_obj [n_src];
    logic [data_width-1:0]    exp_mvec;
    logic [data_width-1:0]    exp_marg;
    int                       exp_id;

    integer seed = 32'h00b12a59;
    int     errors;
    int     checks;

    plic_top #(.num_sources(n_src)) uut (
        .clk         (clk),
        .rst_n       (rst_n),
        .waddr       (waddr),
        .wdata       (wdata),
        .wstrb       (wstrb),
        .wen         (wen),
        .raddr       (raddr),
        .rdata       (rdata),
        .irq_sources (irq_sources),
        .irq_valid   (irq_valid),
        .irq_id      (irq_id),
        .mvec        (mvec),
        .marg        (marg)
    );

    always #5 clk = ~clk;

    function automatic reg_region_e model_region(input logic [addr_width-1:0] a);
        int off_p;
        int off_v;
        int off_o;
        off_p = int'(a) - int'(pri_base);
        off_v = int'(a) - int'(vec_base);
        off_o = int'(a) - int'(obj_base);
        if (a == en_addr) return region_en;
        if (a == id_addr) return region_id;
        if (a == mvec_addr) return region_mvec;
        if (a == marg_addr) return region_marg;
        if (off_p >= 0 && off_p < n_src) return region_pri;
        if (off_v >= 0 && off_v < 4 * n_src && off_v % 4 == 0) return region_vec;
        if (off_o >= 0 && off_o < 4 * n_src && off_o % 4 == 0) return region_obj;
        return region_none;
    endfunction

    function automatic void model_write(input logic [addr_width-1:0] a,
                                        input logic [data_width-1:0] d,
                                        input logic [3:0] s);
        int off;
        off = int'(a) - int'(pri_base);
        case (model_region(a))
            region_en: begin
                for (int b = 0; b < n_src; b++)
                    if (s[b / 8])
                        m_en[b] = d[b];
            end
            region_pri: begin
                for (int k = 0; k < 4; k++)
                    if (s[k] && off + k < n_src)
                        m_pri[off + k] = d[8*k +: 8];
            end
            region_vec: m_vec[(int'(a) - int'(vec_base)) / 4] = d; // strobes ignored
            region_obj: m_obj[(int'(a) - int'(obj_base)) / 4] = d;
            default: ;
        endcase
    endfunction

    function automatic logic [data_width-1:0] model_read(input logic [addr_width-1:0] a);
        logic [data_width-1:0] r;
        int                    off;
        r = '0;
        off = int'(a) - int'(pri_base);
        case (model_region(a))
            region_en:   r = 32'(m_en);
            region_pri: begin
                for (int k = 0; k < 4; k++)
                    if (off + k < n_src)
                        r[8*k +: 8] = m_pri[off + k];
            end
            region_id:   r = 32'(exp_id);
            region_mvec: r = exp_mvec;
            region_marg: r = exp_marg;
            region_vec:  r = m_vec[(int'(a) - int'(vec_base)) / 4];
            region_obj:  r = m_obj[(int'(a) - int'(obj_base)) / 4];
            default: ;
        endcase
        return r;
    endfunction

    // -1 when nothing is pending
    // strict compare keeps the lowest index on ties
    function automatic int model_winner(input logic [n_src-1:0] src);
        int best;
        best = -1;
        for (int i = 0; i < n_src; i++)
            if (src[i] && m_en[i] && (best < 0 || m_pri[i] > m_pri[best]))
                best = i;
        return best;
    endfunction

    task automatic check_val(input string name, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
        checks++;
        if (act_v !== exp_v) begin
            $display("[ERROR] %s expected %h got %h", name, exp_v, act_v);
            errors++;
        end
    endtask

    task automatic write_reg(input logic [addr_width-1:0] a, input logic [data_width-1:0] d,
                             input logic [3:0] s);
        @(posedge clk);
        #1;
        waddr = a;
        wdata = d;
        wstrb = s;
        wen   = 1'b1;
        @(posedge clk);
        model_write(a, d, s);
        #1;
        wen = 1'b0;
    endtask

    task automatic read_check(input logic [addr_width-1:0] a);
        @(posedge clk);
        #1;
        raddr = a;
        @(negedge clk); // rdata is combinational
        check_val($sformatf("rdata@%h", a), model_read(a), rdata);
    endtask

    task automatic read_all_regs();
        read_check(en_addr);
        for (int w = 0; w < 4; w++)
            read_check(pri_base + 12'(4 * w));
        read_check(id_addr);
        read_check(mvec_addr);
        read_check(marg_addr);
        for (int i = 0; i < n_src; i++) begin
            read_check(vec_base + 12'(4 * i));
            read_check(obj_base + 12'(4 * i));
        end
    endtask

    task automatic irq_trial(inout int arb_e, inout int vec_e);
        logic [n_src-1:0] src;
        int               win;
        int               e0;
        @(posedge clk);
        #1;
        irq_sources = '0;
        repeat (4) @(posedge clk); // drain the pipeline
        write_reg(en_addr, $random(seed), 4'hf);
        for (int w = 0; w < 4; w++)
            write_reg(pri_base + 12'(4 * w), $random(seed) & 32'h03030303, 4'hf); // many ties
        src = n_src'($random(seed));
        @(posedge clk);
        #1;
        irq_sources = src;
        repeat (3) @(posedge clk);
        @(negedge clk);
        win = model_winner(src);
        exp_id = (win < 0) ? 0 : win;
        e0 = errors;
        check_val("irq_valid", 32'(win >= 0), 32'(irq_valid));
        check_val("irq_id", 32'(exp_id), 32'(irq_id));
        arb_e += errors - e0;
        if (win >= 0) begin
            exp_mvec = m_vec[win];
            exp_marg = m_obj[win];
        end
        @(negedge clk); // vector stage is one edge later
        e0 = errors;
        check_val("mvec", exp_mvec, mvec);
        check_val("marg", exp_marg, marg);
        read_check(mvec_addr);
        read_check(marg_addr);
        read_check(id_addr);
        vec_e += errors - e0;
    endtask

    initial begin
        #(total_cycles * 10 + 2000);
        $display("timeout, tests did not finish within %0d cycles", total_cycles);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        int                    e0;
        int                    win;
        int                    arb_e;
        int                    vec_e;
        logic [3:0]            strb;
        logic [addr_width-1:0] a;
        logic [n_src-1:0]      src;
        clk         = 1'b0;
        rst_n       = 1'b0;
        waddr       = '0;
        wdata       = '0;
        wstrb       = '0;
        wen         = 1'b0;
        raddr       = '0;
        irq_sources = '0;
        errors      = 0;
        checks      = 0;
        m_en        = '0;
        exp_id      = 0;
        exp_mvec    = '0;
        exp_marg    = '0;
        for (int i = 0; i < n_src; i++) begin
            m_pri[i] = '0;
            m_vec[i] = '0;
            m_obj[i] = '0;
        end
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;

        e0 = errors;
        @(negedge clk);
        check_val("irq_valid", 32'h0, 32'(irq_valid));
        read_all_regs();
        $display("test 1 reset values: %0d errors", errors - e0);

        e0 = errors;
        for (int n = 0; n < n_rw; n++) begin
            case ({$random(seed)} % 8)
                0, 7: a = en_addr;
                1: a = pri_base + 12'({$random(seed)} % 20);     // runs past the last source
                2: a = id_addr + 12'(4 * ({$random(seed)} % 3)); // id, mvec or marg
                3: a = vec_base + 12'(4 * ({$random(seed)} % n_src));
                4: a = obj_base + 12'(4 * ({$random(seed)} % n_src));
                5: a = vec_base + 12'({$random(seed)} % 80);     // some misaligned
                default: a = 12'($random(seed));
            endcase
            strb = 4'($random(seed));
            if (strb == 4'h0)
                strb = 4'h1;
            write_reg(a, $random(seed), strb);
            read_check(a);
        end
        read_all_regs(); // stray writes must not land elsewhere
        $display("test 2 register write and readback: %0d errors", errors - e0);

        for (int i = 0; i < n_src; i++) begin
            write_reg(vec_base + 12'(4 * i), $random(seed), 4'hf);
            write_reg(obj_base + 12'(4 * i), $random(seed), 4'hf);
        end
        arb_e = 0;
        vec_e = 0;
        for (int n = 0; n < n_irq; n++)
            irq_trial(arb_e, vec_e);
        $display("test 3 arbitration: %0d errors", arb_e);
        $display("test 4 vector capture and readback: %0d errors", vec_e);

        e0 = errors;
        write_reg(en_addr, 32'hffff_ffff, 4'hf);
        src = (n_src'($random(seed)) & ~n_src'(1)) | n_src'(2); // winner is never idle id 0
        @(posedge clk);
        #1;
        irq_sources = src;
        repeat (4) @(posedge clk);
        @(negedge clk);
        win = model_winner(src);
        exp_id = win;
        exp_mvec = m_vec[win];
        exp_marg = m_obj[win];
        check_val("irq_valid", 32'h1, 32'(irq_valid));
        check_val("irq_id", 32'(exp_id), 32'(irq_id));
        check_val("mvec", exp_mvec, mvec);
        write_reg(en_addr, 32'h0, 4'hf);
        exp_id = 0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        check_val("irq_valid", 32'h0, 32'(irq_valid));
        check_val("irq_id", 32'h0, 32'(irq_id));
        check_val("mvec", exp_mvec, mvec);
        check_val("marg", exp_marg, marg);
        read_check(mvec_addr);
        read_check(marg_addr);
        $display("test 5 disable holds vectors: %0d errors", errors - e0);

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

//--- compile.f
common/plic_pkg.sv
rtl/irq_gateway.sv
plic_regs/plic_regs.sv
rtl/priority_arbiter.sv
rtl/vector_stage.sv
rtl/plic_top.sv
testbench/tb_plic.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the PLIC testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_plic -f compile.f -Mdir obj_dir \
    || { echo "build failed"; exit 1; }
./obj_dir/Vtb_plic | tee /dev/stderr | grep -F "=== PASS ===" > /dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
